// File: squeeze_consts.svh
`ifndef SQUEEZE_CONSTS_SVH
`define SQUEEZE_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Layer geometry
//////////////////////////////////////////////////////////////////////

// Output lanes, one DSP slice each
`define SQ_LANES 4

// Pixel, weight and output word width
`define SQ_WIDTH 16

// Input channels, also taps per output pixel
`define SQ_CHIN 16

// Output map side, square map
`define SQ_WOUT 4

//////////////////////////////////////////////////////////////////////
// Weight memory split
//////////////////////////////////////////////////////////////////////

// Tap addresses below this come from the block-RAM bank
// The rest are served by the LUT bank
`define SQ_BRAM_DEPTH 12

// Tap address width, covers SQ_CHIN taps
`define SQ_ADDR_W 4

`endif

// File: squeeze_pkg.sv
`include "squeeze_consts.svh"

package squeeze_pkg;

	// Accumulator word, read as a raw sum or as requant fields
	// Field layout matches the Q-format of the lane sums
	typedef union packed {
		logic signed [31:0] raw;
		struct packed {
			// Sign of the biased sum
			logic        sign;
			// Bits above the kept range
			logic [1:0]  guard;
			// Magnitude that reaches the output word
			logic [14:0] mag;
			// Fraction dropped by requantization
			logic [13:0] frac;
		} q;
	} acc_word_u;

	// Fixed weight per lane and tap, wraps into 16 bits
	function automatic logic signed [`SQ_WIDTH-1:0] sq_weight(input int lane, input int tap);
		int full;
		full = ((lane + 1) * (tap + 3)) * 97 - 2000;
		return full[`SQ_WIDTH-1:0];
	endfunction

	// Per-lane bias, lane 0 negative, lane 1 zero
	function automatic logic signed [31:0] sq_bias(input int lane);
		int full;
		full = (lane - 1) * 65536;
		return full;
	endfunction

endpackage

// File: squeeze_ctrl_if.sv
`timescale 1ns/1ps
`include "squeeze_consts.svh"

// Pixel and strobes from the window controller to the MAC lanes
interface squeeze_ctrl_if;

	// Pixel, delayed to meet its weight
	logic [`SQ_WIDTH-1:0] pix;

	// Enable aligned with pix and the kernel register
	logic mac_en;

	// Window boundary, closes the running sum
	logic clr;

	// Output register load, one cycle after clr
	logic load;

	// Window controller side
	modport ctrl (
		output pix,
		output mac_en,
		output clr,
		output load
	);

	// MAC array side
	modport mac (
		input pix,
		input mac_en,
		input clr,
		input load
	);

endinterface

// File: squeeze_weight_fetch.sv
`timescale 1ns/1ps
`include "squeeze_consts.svh"

module squeeze_weight_fetch (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 tap_en,
	input  logic                 tap_wrap,
	output logic [`SQ_WIDTH-1:0] kernel [0:`SQ_LANES-1]
);
	import squeeze_pkg::*;

	// Addresses left over for the LUT bank
	localparam int LUT_DEPTH = (1 << `SQ_ADDR_W) - `SQ_BRAM_DEPTH;
	localparam int LUT_AW    = $clog2(LUT_DEPTH);

	logic [`SQ_ADDR_W-1:0] tap_addr;
	logic [`SQ_WIDTH-1:0]  bram_mem [0:`SQ_BRAM_DEPTH-1][0:`SQ_LANES-1];
	logic [`SQ_WIDTH-1:0]  bram_q   [0:`SQ_LANES-1];
	logic [`SQ_WIDTH-1:0]  lut_data [0:`SQ_LANES-1];
	logic [`SQ_WIDTH-1:0]  lut_q    [0:`SQ_LANES-1];
	logic [LUT_AW-1:0]     lut_off;
	logic                  lut_sel;
	logic                  lut_sel_q;

	//////////////////////////////////////////////////////////////////////
	// Tap address
	//////////////////////////////////////////////////////////////////////

	// Steps once per accepted tap
	// Back to zero on the last tap of a window
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tap_addr <= '0;
		end else if (tap_wrap) begin
			tap_addr <= '0;
		end else if (tap_en) begin
			tap_addr <= tap_addr + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Block-RAM bank, low addresses
	//////////////////////////////////////////////////////////////////////

	// ROM contents, one word per lane at each address
	initial begin
		for (int a = 0; a < `SQ_BRAM_DEPTH; a++) begin
			for (int l = 0; l < `SQ_LANES; l++) begin
				bram_mem[a][l] = sq_weight(l, a);
			end
		end
	end

	// Synchronous read, holds its word outside the bank range
	always_ff @(posedge clk) begin
		if (tap_addr < `SQ_BRAM_DEPTH) begin
			bram_q <= bram_mem[tap_addr];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// LUT bank, high addresses
	//////////////////////////////////////////////////////////////////////

	// Offset into the LUT bank
	assign lut_off = LUT_AW'(tap_addr - `SQ_ADDR_W'(`SQ_BRAM_DEPTH));
	assign lut_sel = (tap_addr >= `SQ_BRAM_DEPTH);

	always_comb begin
		for (int l = 0; l < `SQ_LANES; l++) begin
			lut_data[l] = sq_weight(l, `SQ_BRAM_DEPTH + int'(lut_off));
		end
	end

	// LUT output register, same stage as the bank read
	// Select travels with the data
	always_ff @(posedge clk) begin
		lut_q     <= lut_data;
		lut_sel_q <= lut_sel;
	end

	// Bank-select mux register feeding the multipliers
	always_ff @(posedge clk) begin
		for (int l = 0; l < `SQ_LANES; l++) begin
			kernel[l] <= lut_sel_q ? lut_q[l] : bram_q[l];
		end
	end

endmodule

// File: squeeze_window_ctrl.sv
`timescale 1ns/1ps
`include "squeeze_consts.svh"

module squeeze_window_ctrl (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 layer_en,
	input  logic [`SQ_WIDTH-1:0] ifm,
	input  logic                 ram_feedback,
	output logic                 tap_en,
	output logic                 tap_wrap,
	output logic                 sample,
	output logic                 finish,
	squeeze_ctrl_if.ctrl         ctrl
);

	// Output pixels in the layer
	localparam int NPIX  = `SQ_WOUT * `SQ_WOUT;
	localparam int PIX_W = $clog2(NPIX + 1);

	logic [`SQ_WIDTH-1:0]  pix_r;
	logic [`SQ_WIDTH-1:0]  pix_d1;
	logic                  en_r;
	logic                  en_d1;
	logic [`SQ_ADDR_W-1:0] tap_cnt;
	logic                  wrap_d1;
	logic [PIX_W-1:0]      pix_cnt;
	logic                  layer_end;
	logic                  fb_flag;

	// Input register, then two stages to match the weight path
	always_ff @(posedge clk) begin
		pix_r    <= ifm;
		pix_d1   <= pix_r;
		ctrl.pix <= pix_d1;
	end

	// Registered enable, shared with the weight fetch
	assign tap_en   = en_r & ~layer_end;
	assign tap_wrap = tap_en && (tap_cnt == `SQ_ADDR_W'(`SQ_CHIN - 1));

	//////////////////////////////////////////////////////////////////////
	// Tap counting and strobe pipeline
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			en_r        <= 1'b0;
			en_d1       <= 1'b0;
			ctrl.mac_en <= 1'b0;
			tap_cnt     <= '0;
			wrap_d1     <= 1'b0;
			ctrl.clr    <= 1'b0;
			ctrl.load   <= 1'b0;
			sample      <= 1'b0;
		end else begin
			en_r        <= layer_en;
			// Enable follows the pixel through the same stages
			en_d1       <= tap_en;
			ctrl.mac_en <= en_d1;
			if (tap_en) begin
				tap_cnt <= tap_wrap ? '0 : tap_cnt + 1'b1;
			end
			// Two stages, clr lands on the last product
			wrap_d1   <= tap_wrap;
			ctrl.clr  <= wrap_d1;
			ctrl.load <= ctrl.clr;
			// Strobe while ofm shows the new pixel
			sample    <= ctrl.load;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Layer end and finish
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pix_cnt   <= '0;
			layer_end <= 1'b0;
			fb_flag   <= 1'b0;
		end else begin
			if (ctrl.load && !layer_end) begin
				pix_cnt <= pix_cnt + 1'b1;
				// Last window of the map
				if (pix_cnt == PIX_W'(NPIX - 1)) begin
					layer_end <= 1'b1;
				end
			end
			// Sticky, set by the downstream RAM
			if (ram_feedback) begin
				fb_flag <= 1'b1;
			end
		end
	end

	assign finish = layer_end & ~fb_flag;

endmodule

// File: squeeze_mac_array.sv
`timescale 1ns/1ps
`include "squeeze_consts.svh"

module squeeze_mac_array (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [`SQ_WIDTH-1:0] kernel [0:`SQ_LANES-1],
	squeeze_ctrl_if.mac          ctrl,
	output logic [`SQ_WIDTH-1:0] ofm    [0:`SQ_LANES-1]
);
	import squeeze_pkg::*;

	// Full-precision product and sum width
	localparam int ACC_W = 2 * `SQ_WIDTH;

	genvar g;

	//////////////////////////////////////////////////////////////////////
	// Lanes
	//////////////////////////////////////////////////////////////////////

	generate
		for (g = 0; g < `SQ_LANES; g++) begin : g_lane
			logic signed [ACC_W-1:0]     prod;
			logic signed [ACC_W-1:0]     acc;
			logic signed [ACC_W-1:0]     acc_next;
			acc_word_u                   sum_q;
			acc_word_u                   biased;
			logic        [`SQ_WIDTH-1:0] ofm_q;

			// Signed pixel times signed weight
			assign prod = $signed(ctrl.pix) * $signed(kernel[g]);

			// Bubbles from enable gaps add nothing
			assign acc_next = ctrl.mac_en ? acc + prod : acc;

			// Running sum, restarts after each window
			always_ff @(posedge clk) begin
				if (!rst_n) begin
					acc <= '0;
				end else if (ctrl.clr) begin
					acc <= '0;
				end else begin
					acc <= acc_next;
				end
			end

			// Closed window sum, last product included
			always_ff @(posedge clk) begin
				if (ctrl.clr) begin
					sum_q.raw <= acc_next;
				end
			end

			// Bias add on the raw view
			assign biased.raw = sum_q.raw + sq_bias(g);

			// ReLU then requant through the field view
			always_ff @(posedge clk) begin
				if (!rst_n) begin
					ofm_q <= '0;
				end else if (ctrl.load) begin
					if (biased.q.sign) begin
						ofm_q <= '0;
					end else begin
						// Guard bits and fraction are dropped
						ofm_q <= {1'b0, biased.q.mag};
					end
				end
			end

			assign ofm[g] = ofm_q;
		end
	endgenerate

endmodule

// File: squeeze_layer_top.sv
`timescale 1ns/1ps
`include "squeeze_consts.svh"

module squeeze_layer_top (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           layer_en,
	input  logic [`SQ_WIDTH-1:0]           ifm,
	input  logic                           ram_feedback,
	output logic                           sample,
	output logic                           finish,
	output logic [`SQ_LANES*`SQ_WIDTH-1:0] ofm
);

	logic                 tap_en;
	logic                 tap_wrap;
	logic [`SQ_WIDTH-1:0] kernel   [0:`SQ_LANES-1];
	logic [`SQ_WIDTH-1:0] ofm_lane [0:`SQ_LANES-1];

	genvar g;

	// Pixel and strobes, controller to lanes
	squeeze_ctrl_if ctrl_bus ();

	//////////////////////////////////////////////////////////////////////
	// Blocks
	//////////////////////////////////////////////////////////////////////

	// Weights per lane, three cycles behind the tap
	squeeze_weight_fetch u_weight_fetch (
		.clk      (clk),
		.rst_n    (rst_n),
		.tap_en   (tap_en),
		.tap_wrap (tap_wrap),
		.kernel   (kernel)
	);

	// Counters, strobes, end and finish
	squeeze_window_ctrl u_window_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.layer_en     (layer_en),
		.ifm          (ifm),
		.ram_feedback (ram_feedback),
		.tap_en       (tap_en),
		.tap_wrap     (tap_wrap),
		.sample       (sample),
		.finish       (finish),
		.ctrl         (ctrl_bus.ctrl)
	);

	// Lane MACs and output register
	squeeze_mac_array u_mac_array (
		.clk    (clk),
		.rst_n  (rst_n),
		.kernel (kernel),
		.ctrl   (ctrl_bus.mac),
		.ofm    (ofm_lane)
	);

	// Lane 0 in the low word
	generate
		for (g = 0; g < `SQ_LANES; g++) begin : g_pack
			assign ofm[g*`SQ_WIDTH +: `SQ_WIDTH] = ofm_lane[g];
		end
	endgenerate

endmodule

// File: squeeze_assert.sv
`timescale 1ns/1ps
`include "squeeze_consts.svh"

module squeeze_assert (
	input logic                           clk,
	input logic                           rst_n,
	input logic                           layer_en,
	input logic                           ram_feedback,
	input logic                           sample,
	input logic                           finish,
	input logic [`SQ_LANES*`SQ_WIDTH-1:0] ofm
);

	localparam int NPIX = `SQ_WOUT * `SQ_WOUT;
	// Last tap to sample strobe
	localparam int LAT  = 5;

	logic [LAT-1:0] en_pipe;
	int             taps_since;
	int             taps_now;
	int             samples;
	logic           fb_seen;
	// Read by the testbench at the end of the run
	int             assert_fails = 0;

	// Enable delayed to line up with the strobe
	assign taps_now = taps_since + int'(en_pipe[LAT-1]);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			en_pipe    <= '0;
			taps_since <= 0;
			samples    <= 0;
			fb_seen    <= 1'b0;
		end else begin
			en_pipe    <= {en_pipe[LAT-2:0], layer_en};
			taps_since <= sample ? 0 : taps_now;
			if (sample) begin
				samples <= samples + 1;
			end
			// Same timing as the sticky flag in the DUT
			if (ram_feedback) begin
				fb_seen <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Strobe rules
	//////////////////////////////////////////////////////////////////////

	// One cycle wide
	a_sample_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		sample |=> !sample)
		else begin
			$error("sample held high for more than one cycle");
			assert_fails++;
		end

	// A full window of taps between strobes
	a_window_taps: assert property (@(posedge clk) disable iff (!rst_n)
		sample |-> taps_now == `SQ_CHIN)
		else begin
			$error("sample after %0d taps", taps_now);
			assert_fails++;
		end

	// Output word only moves with the strobe
	a_ofm_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!sample |-> $stable(ofm))
		else begin
			$error("ofm changed without sample");
			assert_fails++;
		end

	// Nothing past the last pixel
	a_sample_count: assert property (@(posedge clk) disable iff (!rst_n)
		sample |-> samples < NPIX)
		else begin
			$error("sample after the last output pixel");
			assert_fails++;
		end

	//////////////////////////////////////////////////////////////////////
	// Finish level
	//////////////////////////////////////////////////////////////////////

	// Rises with the last strobe, holds until feedback
	a_finish_level: assert property (@(posedge clk) disable iff (!rst_n)
		finish == (samples + int'(sample) == NPIX && !fb_seen))
		else begin
			$error("finish level wrong after %0d samples", samples);
			assert_fails++;
		end

endmodule

bind squeeze_layer_top squeeze_assert u_assert (
	.clk          (clk),
	.rst_n        (rst_n),
	.layer_en     (layer_en),
	.ram_feedback (ram_feedback),
	.sample       (sample),
	.finish       (finish),
	.ofm          (ofm)
);

// File: tb_squeeze_layer.sv
`timescale 1ns/1ps
`include "squeeze_consts.svh"

module tb_squeeze_layer;
	import squeeze_pkg::*;

	localparam int NPIX = `SQ_WOUT * `SQ_WOUT;
	localparam int NTAP = NPIX * `SQ_CHIN;
	localparam int TMO  = 400;

	logic                           clk;
	logic                           rst_n;
	logic                           layer_en;
	logic [`SQ_WIDTH-1:0]           ifm;
	logic                           ram_feedback;
	logic                           sample;
	logic                           finish;
	logic [`SQ_LANES*`SQ_WIDTH-1:0] ofm;

	// Every value sent, in stream order
	logic [`SQ_WIDTH-1:0] ifm_log [0:NTAP-1];
	logic [31:0]          rng = 32'h6191c80e;
	int                   errs;
	int                   passed;
	int                   failed;
	int                   zero_seen;
	int                   pos_seen;
	int                   afails;

	squeeze_layer_top squeeze_layer_top_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.layer_en     (layer_en),
		.ifm          (ifm),
		.ram_feedback (ram_feedback),
		.sample       (sample),
		.finish       (finish),
		.ofm          (ofm)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Expected lane word for one output pixel
	function automatic logic [`SQ_WIDTH-1:0] model_lane(input int p, input int l);
		int sum;
		sum = sq_bias(l);
		for (int c = 0; c < `SQ_CHIN; c++) begin
			sum += int'($signed(ifm_log[p*`SQ_CHIN + c])) * int'(sq_weight(l, c));
		end
		// ReLU, then 15 magnitude bits under a zero sign
		if (sum < 0) begin
			return '0;
		end
		return {1'b0, sum[28:14]};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus and checks
	//////////////////////////////////////////////////////////////////////

	// First half back to back, second half with random gaps
	task automatic drive_layer();
		int idx;
		idx = 0;
		for (int cyc = 0; cyc < 8 * NTAP && idx < NTAP; cyc++) begin
			@(posedge clk);
			rng = lcg_next(rng);
			if (idx < NTAP / 2 || rng[31:30] != 2'b00) begin
				ifm_log[idx] = rng[23:8];
				ifm          <= rng[23:8];
				layer_en     <= 1'b1;
				idx++;
			end else begin
				layer_en <= 1'b0;
			end
		end
		// Taps past the map, none of them may open a window
		for (int n = 0; n < 2 * `SQ_CHIN; n++) begin
			@(posedge clk);
			rng      = lcg_next(rng);
			ifm      <= rng[23:8];
			layer_en <= 1'b1;
		end
		@(posedge clk);
		layer_en <= 1'b0;
	endtask

	task automatic wait_sample(output bit seen);
		seen = 1'b0;
		for (int n = 0; n < TMO && !seen; n++) begin
			@(negedge clk);
			seen = sample;
		end
	endtask

	task automatic check_pixel(input int p);
		logic [`SQ_WIDTH-1:0] exp_v;
		logic [`SQ_WIDTH-1:0] got;
		for (int l = 0; l < `SQ_LANES; l++) begin
			exp_v = model_lane(p, l);
			got   = ofm[l*`SQ_WIDTH +: `SQ_WIDTH];
			if (exp_v == '0) begin
				zero_seen++;
			end else begin
				pos_seen++;
			end
			assert (got == exp_v) else begin
				$display("** Error pixel %0d ofm lane %0d: got %h expected %h", p, l, got, exp_v);
				errs++;
			end
		end
	endtask

	task automatic end_test(input int num, input string name);
		if (errs == 0) begin
			passed++;
			$display("test %0d %s: ok", num, name);
		end else begin
			failed++;
			$display("test %0d %s: %0d errors", num, name, errs);
		end
		errs = 0;
	endtask

	initial begin
		bit seen;
		rst_n        = 1'b0;
		layer_en     = 1'b0;
		ifm          = '0;
		ram_feedback = 1'b0;
		errs         = 0;
		passed       = 0;
		failed       = 0;
		zero_seen    = 0;
		pos_seen     = 0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		fork
			drive_layer();
		join_none

		// Outputs quiet until the first window closes
		seen = 1'b0;
		for (int n = 0; n < TMO && !seen; n++) begin
			@(negedge clk);
			seen = sample;
			assert (seen || (!finish && ofm == '0)) else begin
				$display("** Error before first window: finish %h ofm %h", finish, ofm);
				errs++;
			end
		end
		end_test(1, "reset state");

		for (int p = 0; p < NPIX; p++) begin
			if (p > 0) begin
				wait_sample(seen);
			end
			if (seen) begin
				check_pixel(p);
			end else begin
				$display("timeout while waiting for the sample of pixel %0d", p);
				errs++;
			end
			if (p == NPIX / 2 - 1) begin
				end_test(2, "continuous enable");
			end
		end
		end_test(4, "enable gaps");

		// Both sides of the ReLU must have been hit
		assert (zero_seen > 0 && pos_seen > 0) else begin
			$display("only %0d zero and %0d positive lane words seen", zero_seen, pos_seen);
			errs++;
		end
		end_test(3, "relu and requant");

		seen = 1'b0;
		for (int n = 0; n < TMO && !seen; n++) begin
			@(negedge clk);
			seen = finish;
		end
		if (!seen) begin
			$display("timeout while waiting for finish");
			errs++;
		end
		// No strobe once the map is done
		for (int n = 0; n < 40; n++) begin
			@(negedge clk);
			assert (!sample) else begin
				$display("sample strobe after the last output pixel");
				errs++;
			end
		end
		@(posedge clk);
		ram_feedback <= 1'b1;
		@(posedge clk);
		ram_feedback <= 1'b0;
		seen = 1'b0;
		for (int n = 0; n < TMO && !seen; n++) begin
			@(negedge clk);
			seen = !finish;
		end
		if (!seen) begin
			$display("timeout while waiting for finish to drop");
			errs++;
		end
		for (int n = 0; n < 20; n++) begin
			@(negedge clk);
			assert (!finish) else begin
				$display("** Error finish back high: got %h expected %h", finish, 1'b0);
				errs++;
			end
		end
		end_test(5, "finish and feedback");

		afails = squeeze_layer_top_inst.u_assert.assert_fails;
		$display("%0d tests passed, %0d failed, %0d assertion failures", passed, failed, afails);
		if (failed == 0 && afails == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+.
squeeze_pkg.sv
squeeze_ctrl_if.sv
squeeze_weight_fetch.sv
squeeze_window_ctrl.sv
squeeze_mac_array.sv
squeeze_layer_top.sv
squeeze_assert.sv
tb_squeeze_layer.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_squeeze_layer
FLIST    := filelist.f
OBJ      := obj_dir
RUN_ARGS := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)

run: build
	@out="$$(./$(OBJ)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ)
